// File: all.f
+incdir+testbench
common/cp0Pkg.sv
hdl/cp0Timer.sv
hdl/cp0ExcUnit.sv
hdl/cp0StatusRegs.sv
hdl/cp0ReadMux.sv
hdl/cp0Top.sv
testbench/cp0Tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cp0Tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: testbench/cp0TbTasks.svh
// ========================================
// CP0 testbench helpers
// Register access, exception strobes,
// random words and value checks
// ========================================
`ifndef CP0_TB_TASKS_SVH
`define CP0_TB_TASKS_SVH

logic [31:0] lcgState = 32'h02df20b0;

function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
endfunction

task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
    checkCount++;
    if (got !== exp) begin
        errorCount++;
        $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
endtask

// One write strobe, returns after the sampling edge
task automatic writeReg(input logic [4:0] addr, input logic [31:0] data);
    @(posedge clk);
    #1;
    access.addr  = addr;
    access.wen   = 1'b1;
    access.wdata = data;
    @(posedge clk);
    #1;
    access.wen = 1'b0;
endtask

task automatic readReg(input logic [4:0] addr, output logic [31:0] data);
    @(posedge clk);
    #1;
    access.addr = addr;
    access.wen  = 1'b0;
    @(negedge clk);    // Read path settled
    data = rdata;
endtask

task automatic readCheck(input string name, input logic [4:0] addr, input logic [31:0] exp);
    logic [31:0] got;
    readReg(addr, got);
    checkWord(name, got, exp);
endtask

task automatic raiseExc(input excType_t kind, input logic [31:0] pc, input logic [31:0] bad,
                        input logic isStore, input logic inSlot);
    @(posedge clk);
    #1;
    excReq.valid    = 1'b1;
    excReq.excType  = kind;
    excReq.pc       = pc;
    excReq.badVAddr = bad;
    excReq.cpNum    = 2'd0;
    excReq.isStore  = isStore;
    excReq.inSlot   = inSlot;
    @(posedge clk);
    #1;
    excReq.valid = 1'b0;
endtask

// 0 is the interrupt request, anything else Cause.IP7
function automatic bit condMet(input int which);
    if (which == 0) begin
        return excIntr === 1'b1;
    end
    return cause.ip[7] === 1'b1;
endfunction

task automatic waitFor(input int which, input int limit, input string what);
    int n;
    n = 0;
    while (!condMet(which) && n < limit) begin
        @(negedge clk);
        n++;
    end
    if (!condMet(which)) begin
        errorCount++;
        $display("Timeout: no %s within %0d cycles", what, limit);
    end
endtask

`endif

// File: testbench/cp0Tb.sv
// ========================================
// CP0 testbench
// Directed tests for registers, exception
// entry, interrupts and the timer
// ========================================
`timescale 1ns/1ps

module cp0Tb import cp0Pkg::*; ();

    localparam logic [31:0] STATUS_WMASK = 32'h1040_FF17;  // CU0 BEV IM UM ERL EXL IE
    localparam logic [31:0] CAUSE_WMASK  = 32'h0080_0300;  // IV and IP[1:0]

    logic                 clk = 1'b0;
    logic                 rst;
    cp0Access_t           access;
    cp0ExcReq_t           excReq;
    logic [HW_INTR_W-1:0] hwIntr;
    logic [WORD_W-1:0]    rdata;
    statusReg_t           status;
    causeReg_t            cause;
    logic [WORD_W-1:0]    epc;
    logic                 excIntr;
    logic                 userMode;
    int                   errorCount = 0;
    int                   checkCount = 0;

    `include "cp0TbTasks.svh"

    always #5 clk = ~clk;

    cp0Top dut0 (
        .clk        (clk),
        .rst        (rst),
        .access_i   (access),
        .excReq_i   (excReq),
        .hwIntr_i   (hwIntr),
        .rdata_o    (rdata),
        .status_o   (status),
        .cause_o    (cause),
        .epc_o      (epc),
        .excIntr_o  (excIntr),
        .userMode_o (userMode)
    );

    task automatic driveHw(input logic [HW_INTR_W-1:0] value);
        @(posedge clk);
        #1;
        hwIntr = value;
    endtask

    task automatic resetValues();
        readCheck("Status", ADDR_STATUS, 32'h0040_0004);
        readCheck("Cause", ADDR_CAUSE, 32'h0);
        readCheck("ErrorEPC", ADDR_ERROREPC, 32'hBFC0_0000);
        readCheck("PrId", ADDR_PRID, 32'h0001_8000);
        readCheck("Config", ADDR_CONFIG, 32'h8000_0002);
        readCheck("unused register 3", 5'd3, 32'h0);
        checkWord("excIntr_o", {31'd0, excIntr}, 32'd0);
        checkWord("userMode_o", {31'd0, userMode}, 32'd0);
    endtask

    task automatic regReadWrite();
        logic [31:0] r;
        r = nextRand();
        writeReg(ADDR_EPC, r);
        readCheck("EPC", ADDR_EPC, r);
        r = nextRand();
        writeReg(ADDR_BADVADDR, r);
        readCheck("BadVAddr", ADDR_BADVADDR, r);
        r = nextRand();
        writeReg(ADDR_ERROREPC, r);
        readCheck("ErrorEPC", ADDR_ERROREPC, r);
        r = nextRand();
        writeReg(ADDR_STATUS, r);
        readCheck("Status", ADDR_STATUS, r & STATUS_WMASK);
        r = nextRand();
        writeReg(ADDR_CAUSE, r);
        readCheck("Cause", ADDR_CAUSE, r & CAUSE_WMASK);
        writeReg(ADDR_CAUSE, 32'h0);
        writeReg(ADDR_PRID, nextRand());
        readCheck("PrId", ADDR_PRID, 32'h0001_8000);
        // UM alone, then with EXL, then with ERL
        writeReg(ADDR_STATUS, 32'h0000_0010);
        checkWord("userMode_o", {31'd0, userMode}, 32'd1);
        writeReg(ADDR_STATUS, 32'h0000_0012);
        checkWord("userMode_o", {31'd0, userMode}, 32'd0);
        writeReg(ADDR_STATUS, 32'h0000_0014);
        checkWord("userMode_o", {31'd0, userMode}, 32'd0);
        writeReg(ADDR_STATUS, 32'h0040_0004);
    endtask

    task automatic exceptionEntry();
        logic [31:0] pc;
        logic [31:0] firstEpc;
        logic [31:0] bad;
        logic [31:0] word;
        logic [31:0] keep;
        pc = nextRand() & ~32'h3;
        firstEpc = pc - 32'd4;             // Delay slot points at the branch
        raiseExc(EXC_SYSC, pc, 32'h0, 1'b0, 1'b1);
        readCheck("EPC", ADDR_EPC, firstEpc);
        checkWord("epc_o", epc, firstEpc);
        readReg(ADDR_CAUSE, word);
        checkWord("Cause.BD", {31'd0, word[31]}, 32'd1);
        checkWord("Cause.ExcCode", {27'd0, word[6:2]}, 32'd8);
        checkWord("Status.EXL", {31'd0, status.exl}, 32'd1);
        raiseExc(EXC_OV, nextRand() & ~32'h3, 32'h0, 1'b0, 1'b0);
        readCheck("EPC", ADDR_EPC, firstEpc);
        readReg(ADDR_CAUSE, word);
        checkWord("Cause.ExcCode", {27'd0, word[6:2]}, 32'd12);
        bad = nextRand();
        raiseExc(EXC_ADE, nextRand() & ~32'h3, bad, 1'b1, 1'b0);
        readCheck("BadVAddr", ADDR_BADVADDR, bad);
        readReg(ADDR_CAUSE, word);
        checkWord("Cause.ExcCode", {27'd0, word[6:2]}, 32'd5);
        raiseExc(EXC_ERET, 32'h0, 32'h0, 1'b0, 1'b0);
        checkWord("Status.EXL", {31'd0, status.exl}, 32'd0);

        // Breakpoint together with an ErrorEPC write
        readReg(ADDR_ERROREPC, keep);
        pc = nextRand() & ~32'h3;
        @(posedge clk);
        #1;
        access.addr     = ADDR_ERROREPC;
        access.wen      = 1'b1;
        access.wdata    = nextRand();
        excReq.valid    = 1'b1;
        excReq.excType  = EXC_BP;
        excReq.pc       = pc;
        excReq.badVAddr = 32'h0;
        excReq.isStore  = 1'b0;
        excReq.inSlot   = 1'b0;
        @(posedge clk);
        #1;
        access.wen   = 1'b0;
        excReq.valid = 1'b0;
        readCheck("ErrorEPC", ADDR_ERROREPC, keep);
        readCheck("EPC", ADDR_EPC, pc);
        raiseExc(EXC_ERET, 32'h0, 32'h0, 1'b0, 1'b0);
    endtask

    task automatic interruptRequests();
        writeReg(ADDR_STATUS, 32'h0040_FF01);    // IE with all IM
        driveHw(6'b000100);                       // Line 2 lands in IP4
        waitFor(0, 20, "interrupt request from hardware line 2");
        checkWord("Cause.IP", {24'd0, cause.ip}, 32'h10);
        driveHw('0);
        writeReg(ADDR_CAUSE, 32'h0000_0200);
        waitFor(0, 20, "interrupt request from software IP1");
        checkWord("Cause.IP", {24'd0, cause.ip}, 32'h02);
        writeReg(ADDR_STATUS, 32'h0040_FF03);    // EXL masks the request
        checkWord("excIntr_o", {31'd0, excIntr}, 32'd0);
        writeReg(ADDR_CAUSE, 32'h0);
        writeReg(ADDR_STATUS, 32'h0040_0004);
    endtask

    task automatic countCompare();
        logic [31:0] first;
        logic [31:0] second;
        logic [31:0] word;
        readReg(ADDR_COUNT, first);
        repeat (5) @(posedge clk);
        readReg(ADDR_COUNT, second);
        // Six edges apart at one step per two cycles
        checkWord("Count", second, first + 32'd3);
        writeReg(ADDR_COUNT, 32'h0);
        writeReg(ADDR_COMPARE, 32'd20);
        waitFor(1, 200, "timer interrupt in Cause.IP7");
        writeReg(ADDR_COMPARE, 32'hFFFF_0000);
        readReg(ADDR_CAUSE, word);
        checkWord("Cause.IP7", {31'd0, word[15]}, 32'd0);
    endtask

    initial begin
        rst    = 1'b1;
        access = '0;
        excReq = '0;
        hwIntr = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        resetValues();
        regReadWrite();
        exceptionEntry();
        interruptRequests();
        countCompare();
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: hdl/cp0Top.sv
// ========================================
// CP0 top level
// Timer, exception decode, register block
// and read select
// ========================================
`timescale 1ns/1ps

module cp0Top import cp0Pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  cp0Access_t           access_i,
    input  cp0ExcReq_t           excReq_i,
    input  logic [HW_INTR_W-1:0] hwIntr_i,
    output logic [WORD_W-1:0]    rdata_o,
    output statusReg_t           status_o,
    output causeReg_t            cause_o,
    output logic [WORD_W-1:0]    epc_o,
    output logic                 excIntr_o,
    output logic                 userMode_o
);

    logic [WORD_W-1:0] count;
    logic [WORD_W-1:0] compare;
    logic              timerIntr;
    excUpdate_t        excUpdate;
    logic [WORD_W-1:0] badVAddr;
    logic [WORD_W-1:0] errorEpc;
    logic [WORD_W-1:0] configWord;

    cp0Timer timer0 (
        .clk         (clk),
        .rst         (rst),
        .access_i    (access_i),
        .count_o     (count),
        .compare_o   (compare),
        .timerIntr_o (timerIntr)
    );

    cp0ExcUnit excUnit0 (
        .excReq_i    (excReq_i),
        .status_i    (status_o),
        .excUpdate_o (excUpdate)
    );

    cp0StatusRegs regs0 (
        .clk         (clk),
        .rst         (rst),
        .access_i    (access_i),
        .excValid_i  (excReq_i.valid),
        .excUpdate_i (excUpdate),
        .hwIntr_i    (hwIntr_i),
        .timerIntr_i (timerIntr),
        .status_o    (status_o),
        .cause_o     (cause_o),
        .epc_o       (epc_o),
        .badVAddr_o  (badVAddr),
        .errorEpc_o  (errorEpc),
        .config_o    (configWord),
        .excIntr_o   (excIntr_o),
        .userMode_o  (userMode_o)
    );

    cp0ReadMux readMux0 (
        .addr_i      (access_i.addr),
        .count_i     (count),
        .compare_i   (compare),
        .status_i    (status_o),
        .cause_i     (cause_o),
        .epc_i       (epc_o),
        .badVAddr_i  (badVAddr),
        .errorEpc_i  (errorEpc),
        .config_i    (configWord),
        .rdata_o     (rdata_o)
    );

endmodule

// File: hdl/cp0ReadMux.sv
// ========================================
// CP0 read select
// Picks the register word for the access
// address, zero for unused numbers
// ========================================
`timescale 1ns/1ps

module cp0ReadMux import cp0Pkg::*; (
    input  logic [4:0]        addr_i,
    input  logic [WORD_W-1:0] count_i,
    input  logic [WORD_W-1:0] compare_i,
    input  statusReg_t        status_i,
    input  causeReg_t         cause_i,
    input  logic [WORD_W-1:0] epc_i,
    input  logic [WORD_W-1:0] badVAddr_i,
    input  logic [WORD_W-1:0] errorEpc_i,
    input  logic [WORD_W-1:0] config_i,
    output logic [WORD_W-1:0] rdata_o
);

    always_comb begin
        case (addr_i)
            ADDR_BADVADDR: rdata_o = badVAddr_i;
            ADDR_COUNT:    rdata_o = count_i;
            ADDR_COMPARE:  rdata_o = compare_i;
            ADDR_STATUS:   rdata_o = status_i;
            ADDR_CAUSE:    rdata_o = cause_i;
            ADDR_EPC:      rdata_o = epc_i;
            ADDR_PRID:     rdata_o = PRID_VALUE;   // Fixed processor id
            ADDR_CONFIG:   rdata_o = config_i;
            ADDR_ERROREPC: rdata_o = errorEpc_i;
            default:       rdata_o = '0;
        endcase
    end

endmodule

// File: hdl/cp0StatusRegs.sv
// ========================================
// CP0 register block
// Status, Cause, EPC, BadVAddr, ErrorEPC
// and Config, with interrupt request and
// user-mode outputs
// ========================================
`timescale 1ns/1ps

module cp0StatusRegs import cp0Pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  cp0Access_t           access_i,
    input  logic                 excValid_i,
    input  excUpdate_t           excUpdate_i,
    input  logic [HW_INTR_W-1:0] hwIntr_i,
    input  logic                 timerIntr_i,
    output statusReg_t           status_o,
    output causeReg_t            cause_o,
    output logic [WORD_W-1:0]    epc_o,
    output logic [WORD_W-1:0]    badVAddr_o,
    output logic [WORD_W-1:0]    errorEpc_o,
    output logic [WORD_W-1:0]    config_o,
    output logic                 excIntr_o,
    output logic                 userMode_o
);

    statusReg_t        statusQ;
    causeReg_t         causeQ;
    logic [WORD_W-1:0] epcQ;
    logic [WORD_W-1:0] badVAddrQ;
    logic [WORD_W-1:0] errorEpcQ;
    logic [2:0]        configK0Q;
    statusReg_t        wrStatus;
    causeReg_t         wrCause;
    logic              kernelLevel;

    // Write data seen through the register layouts
    assign wrStatus = statusReg_t'(access_i.wdata);
    assign wrCause  = causeReg_t'(access_i.wdata);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            statusQ     <= '0;
            statusQ.bev <= 1'b1;
            statusQ.erl <= 1'b1;
            causeQ      <= '0;
            errorEpcQ   <= ERROREPC_RESET;
            configK0Q   <= CONFIG_K0_RESET;
        end else begin
            // IP7 shares hardware line 5 with the timer
            causeQ.ip[7:2] <= {hwIntr_i[HW_INTR_W-1] | timerIntr_i,
                               hwIntr_i[HW_INTR_W-2:0]};

            if (excValid_i) begin
                if (excUpdate_i.setExl) begin
                    statusQ.exl <= 1'b1;
                end else if (excUpdate_i.clrExl) begin
                    statusQ.exl <= 1'b0;
                end
                if (excUpdate_i.writeEpc)  causeQ.bd      <= excUpdate_i.bd;
                if (excUpdate_i.writeCode) causeQ.excCode <= excUpdate_i.excCode;
                if (excUpdate_i.writeCe)   causeQ.ce      <= excUpdate_i.ce;
            end else if (access_i.wen) begin
                case (access_i.addr)
                    ADDR_STATUS: begin
                        statusQ.cu0 <= wrStatus.cu0;
                        statusQ.bev <= wrStatus.bev;
                        statusQ.im  <= wrStatus.im;
                        statusQ.um  <= wrStatus.um;
                        statusQ.erl <= wrStatus.erl;
                        statusQ.exl <= wrStatus.exl;
                        statusQ.ie  <= wrStatus.ie;
                    end
                    ADDR_CAUSE: begin
                        causeQ.iv      <= wrCause.iv;
                        causeQ.ip[1:0] <= wrCause.ip[1:0];   // Software interrupts
                    end
                    ADDR_ERROREPC: errorEpcQ <= access_i.wdata;
                    ADDR_CONFIG:   configK0Q <= access_i.wdata[2:0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (excValid_i) begin
            if (excUpdate_i.writeEpc)      epcQ      <= excUpdate_i.epc;
            if (excUpdate_i.writeBadVAddr) badVAddrQ <= excUpdate_i.badVAddr;
        end else if (access_i.wen) begin
            if (access_i.addr == ADDR_EPC)      epcQ      <= access_i.wdata;
            if (access_i.addr == ADDR_BADVADDR) badVAddrQ <= access_i.wdata;
        end
    end

    assign status_o   = statusQ;
    assign cause_o    = causeQ;
    assign epc_o      = epcQ;
    assign badVAddr_o = badVAddrQ;
    assign errorEpc_o = errorEpcQ;
    assign config_o   = CONFIG_FIXED | {{(WORD_W-3){1'b0}}, configK0Q};

    // Exception or error level active
    assign kernelLevel = statusQ.exl | statusQ.erl;

    assign excIntr_o  = (|(causeQ.ip & statusQ.im)) && statusQ.ie && !kernelLevel;
    assign userMode_o = statusQ.um && !kernelLevel;

endmodule

// File: hdl/cp0ExcUnit.sv
// ========================================
// CP0 exception decode
// Turns an exception request into the
// register updates for the status block
// ========================================
`timescale 1ns/1ps

module cp0ExcUnit import cp0Pkg::*; (
    input  cp0ExcReq_t excReq_i,
    input  statusReg_t status_i,
    output excUpdate_t excUpdate_o
);

    logic [4:0]        excCode;
    logic [WORD_W-1:0] pcMinus4;

    assign pcMinus4 = excReq_i.pc - 32'd4;

    always_comb begin
        case (excReq_i.excType)
            EXC_INTR: excCode = EXCC_INT;
            EXC_CPU:  excCode = EXCC_CPU;
            EXC_RI:   excCode = EXCC_RI;
            EXC_OV:   excCode = EXCC_OV;
            EXC_TRAP: excCode = EXCC_TR;
            EXC_SYSC: excCode = EXCC_SYS;
            EXC_BP:   excCode = EXCC_BP;
            EXC_ADE:  excCode = excReq_i.isStore ? EXCC_ADES : EXCC_ADEL;
            default:  excCode = EXCC_INT;
        endcase
    end

    always_comb begin
        excUpdate_o = '0;
        if (excReq_i.valid) begin
            case (excReq_i.excType)
                EXC_INTR,
                EXC_CPU,
                EXC_RI,
                EXC_OV,
                EXC_TRAP,
                EXC_SYSC,
                EXC_BP,
                EXC_ADE: begin
                    excUpdate_o.setExl    = 1'b1;
                    excUpdate_o.writeCode = 1'b1;
                    excUpdate_o.excCode   = excCode;
                    // Nested exception keeps the first return point
                    if (!status_i.exl) begin
                        excUpdate_o.writeEpc = 1'b1;
                        excUpdate_o.epc      = excReq_i.inSlot ? pcMinus4 : excReq_i.pc;
                        excUpdate_o.bd       = excReq_i.inSlot;
                    end
                end
                EXC_ERET: begin
                    excUpdate_o.clrExl = 1'b1;
                end
                default: begin
                    excUpdate_o = '0;
                end
            endcase

            if (excReq_i.excType == EXC_ADE) begin
                excUpdate_o.writeBadVAddr = 1'b1;
                excUpdate_o.badVAddr      = excReq_i.badVAddr;
            end

            if (excReq_i.excType == EXC_CPU) begin
                excUpdate_o.writeCe = 1'b1;
                excUpdate_o.ce      = excReq_i.cpNum;
            end
        end
    end

endmodule

// File: hdl/cp0Timer.sv
// ========================================
// CP0 timer
// Count/Compare pair with the timer
// interrupt flag
// ========================================
`timescale 1ns/1ps

module cp0Timer import cp0Pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  cp0Access_t        access_i,
    output logic [WORD_W-1:0] count_o,
    output logic [WORD_W-1:0] compare_o,
    output logic              timerIntr_o
);

    logic [WORD_W:0]   countQ;   // LSB halves the rate
    logic [WORD_W-1:0] compareQ;
    logic              intrQ;
    logic              timerMatch;
    logic              countWrite;
    logic              compareWrite;

    assign count_o   = countQ[WORD_W:1];
    assign compare_o = compareQ;

    assign timerMatch   = (count_o == compareQ) && (compareQ != '0);
    assign countWrite   = access_i.wen && (access_i.addr == ADDR_COUNT);
    assign compareWrite = access_i.wen && (access_i.addr == ADDR_COMPARE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            countQ   <= '0;
            compareQ <= '0;
            intrQ    <= 1'b0;
        end else begin
            if (countWrite) begin
                countQ <= {access_i.wdata, 1'b0};
            end else begin
                countQ <= countQ + 1'b1;
            end

            if (compareWrite) begin
                compareQ <= access_i.wdata;
                intrQ    <= 1'b0;             // Write acknowledges the timer
            end else if (timerMatch) begin
                intrQ <= 1'b1;
            end
        end
    end

    assign timerIntr_o = intrQ;

endmodule

// File: common/cp0Pkg.sv
// ========================================
// CP0 package
// Register addresses, exception types and
// codes, reset constants and shared structs
// ========================================

package cp0Pkg;

    localparam int WORD_W    = 32;
    localparam int HW_INTR_W = 6;

    // Register numbers
    localparam logic [4:0] ADDR_BADVADDR = 5'd8;
    localparam logic [4:0] ADDR_COUNT    = 5'd9;
    localparam logic [4:0] ADDR_COMPARE  = 5'd11;
    localparam logic [4:0] ADDR_STATUS   = 5'd12;
    localparam logic [4:0] ADDR_CAUSE    = 5'd13;
    localparam logic [4:0] ADDR_EPC      = 5'd14;
    localparam logic [4:0] ADDR_PRID     = 5'd15;
    localparam logic [4:0] ADDR_CONFIG   = 5'd16;
    localparam logic [4:0] ADDR_ERROREPC = 5'd30;

    typedef enum logic [3:0] {
        EXC_NONE = 4'd0,
        EXC_INTR = 4'd1,
        EXC_CPU  = 4'd2,
        EXC_RI   = 4'd3,
        EXC_OV   = 4'd4,
        EXC_TRAP = 4'd5,
        EXC_SYSC = 4'd6,
        EXC_BP   = 4'd7,
        EXC_ADE  = 4'd8,
        EXC_ERET = 4'd9
    } excType_t;

    // Cause.ExcCode values
    localparam logic [4:0] EXCC_INT  = 5'd0;
    localparam logic [4:0] EXCC_ADEL = 5'd4;
    localparam logic [4:0] EXCC_ADES = 5'd5;
    localparam logic [4:0] EXCC_SYS  = 5'd8;
    localparam logic [4:0] EXCC_BP   = 5'd9;
    localparam logic [4:0] EXCC_RI   = 5'd10;
    localparam logic [4:0] EXCC_CPU  = 5'd11;
    localparam logic [4:0] EXCC_OV   = 5'd12;
    localparam logic [4:0] EXCC_TR   = 5'd13;

    localparam logic [WORD_W-1:0] PRID_VALUE     = 32'h0001_8000;
    localparam logic [WORD_W-1:0] ERROREPC_RESET = 32'hBFC0_0000;
    localparam logic [2:0]        CONFIG_K0_RESET = 3'd2;        // Uncached
    localparam logic [WORD_W-1:0] CONFIG_FIXED   = 32'h8000_0000; // M bit, MT none

    typedef struct packed {
        logic [4:0]        addr;
        logic              wen;
        logic [WORD_W-1:0] wdata;
    } cp0Access_t;

    typedef struct packed {
        logic              valid;
        excType_t          excType;
        logic [WORD_W-1:0] pc;
        logic [WORD_W-1:0] badVAddr;
        logic [1:0]        cpNum;
        logic              isStore;
        logic              inSlot;
    } cp0ExcReq_t;

    typedef struct packed {
        logic              writeEpc;
        logic [WORD_W-1:0] epc;
        logic              bd;
        logic              setExl;
        logic              clrExl;
        logic              writeCode;
        logic [4:0]        excCode;
        logic              writeBadVAddr;
        logic [WORD_W-1:0] badVAddr;
        logic              writeCe;
        logic [1:0]        ce;
    } excUpdate_t;

    typedef struct packed {
        logic [2:0] rsvd31;
        logic       cu0;    // 28
        logic [4:0] rsvd27;
        logic       bev;    // 22
        logic [5:0] rsvd21;
        logic [7:0] im;     // 15:8
        logic [2:0] rsvd7;
        logic       um;     // 4
        logic       rsvd3;
        logic       erl;
        logic       exl;
        logic       ie;
    } statusReg_t;

    typedef struct packed {
        logic       bd;      // 31
        logic       rsvd30;
        logic [1:0] ce;      // 29:28
        logic [3:0] rsvd27;
        logic       iv;      // 23
        logic [6:0] rsvd22;
        logic [7:0] ip;      // 15:8
        logic       rsvd7;
        logic [4:0] excCode; // 6:2
        logic [1:0] rsvd1;
    } causeReg_t;

endpackage
